// ==== hdl/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;  // Register 0 means no write.

    // Codes follow the existing decoder, so NOP stays all ones.
    typedef enum logic [4:0] {
        ADD = 5'b00000,
        AND = 5'b00001,
        OR  = 5'b00010,
        SLL = 5'b00011,
        SRL = 5'b00100,
        SLT = 5'b00101,
        SUB = 5'b01000,
        XOR = 5'b01001,
        BEQ = 5'b01010,
        BGE = 5'b01011,
        BNE = 5'b01100,
        LUI = 5'b01110,
        JAL = 5'b10000,
        LW  = 5'b10100,
        SW  = 5'b11001,
        BLT = 5'b11010,
        NOP = 5'b11111
    } op_t;

    function automatic logic is_branch(op_t op);
        return op inside {BEQ, BNE, BLT, BGE};
    endfunction

    function automatic logic is_mem(op_t op);
        return op inside {LW, SW};
    endfunction

    // Result known at dispatch, never issued.
    function automatic logic done_at_dispatch(op_t op);
        return op inside {LUI, JAL, NOP};
    endfunction

endpackage

// ==== hdl/rob_pkg.sv ====
package rob_pkg;

    localparam int ROB_DEPTH = 8;
    localparam int MEM_WORDS = 64;

    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;
    typedef logic [$clog2(ROB_DEPTH):0]   rob_cnt_t;  // Occupancy, 0 to ROB_DEPTH.

    typedef enum logic [1:0] {
        EXECUTING      = 2'b00,
        MEM_READY      = 2'b01,  // Address known, waiting for head.
        DONE_NOT_TAKEN = 2'b10,
        DONE           = 2'b11
    } entry_state_t;

    typedef enum logic [1:0] {
        VALUE      = 2'b00,
        TAKEN      = 2'b01,
        NOT_TAKEN  = 2'b10,
        ADDR_READY = 2'b11
    } result_kind_t;

endpackage

// ==== hdl/rob_ifs.sv ====
interface exec_if;
    import isa_pkg::*;
    import rob_pkg::*;

    logic     valid;  // One-cycle issue pulse.
    op_t      op;
    rob_tag_t tag;
    word_t    a;
    word_t    b;
    word_t    imm;
    word_t    pc;

    modport issuer (
        output valid, op, tag, a, b, imm, pc
    );

    modport unit (
        input valid, op, tag, a, b, imm, pc
    );
endinterface

interface cdb_if;
    import isa_pkg::*;
    import rob_pkg::*;

    logic         valid;  // One-cycle completion pulse.
    rob_tag_t     tag;
    result_kind_t kind;
    word_t        value;

    modport producer (
        output valid, tag, kind, value
    );

    modport consumer (
        input valid, tag, kind, value
    );
endinterface

// ==== hdl/alu_unit.sv ====
module alu_unit (
    input  logic    clk,
    input  logic    rst,
    exec_if.unit    iss,
    cdb_if.producer res
);
    import isa_pkg::*;
    import rob_pkg::*;

    word_t        alu_value;
    logic         taken;
    result_kind_t kind;

    always_comb begin
        case (iss.op)
            ADD:     alu_value = iss.a + iss.b;
            SUB:     alu_value = iss.a - iss.b;
            AND:     alu_value = iss.a & iss.b;
            OR:      alu_value = iss.a | iss.b;
            XOR:     alu_value = iss.a ^ iss.b;
            SLT:     alu_value = {31'b0, $signed(iss.a) < $signed(iss.b)};
            SLL:     alu_value = iss.a << iss.b[4:0];
            SRL:     alu_value = iss.a >> iss.b[4:0];
            default: alu_value = '0;  // Branches carry no value.
        endcase
    end

    always_comb begin
        case (iss.op)
            BEQ:     taken = (iss.a == iss.b);
            BNE:     taken = (iss.a != iss.b);
            BLT:     taken = ($signed(iss.a) < $signed(iss.b));
            BGE:     taken = ($signed(iss.a) >= $signed(iss.b));
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (is_branch(iss.op)) begin
            kind = taken ? TAKEN : NOT_TAKEN;
        end else begin
            kind = VALUE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= iss.valid;
        end
    end

    // Single output stage, a new op may enter every cycle.
    always_ff @(posedge clk) begin
        res.tag   <= iss.tag;
        res.kind  <= kind;
        res.value <= alu_value;
    end

endmodule

// ==== hdl/lsu_unit.sv ====
module lsu_unit (
    input  logic              clk,
    input  logic              rst,
    exec_if.unit              iss,
    cdb_if.producer           res,
    input  logic              mem_go,
    input  rob_pkg::rob_tag_t mem_go_tag
);
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    // Address buffer, one slot per reorder-buffer entry.
    word_t addr_q [ROB_DEPTH];
    word_t data_q [ROB_DEPTH];
    op_t   op_q   [ROB_DEPTH];

    word_t mem [MEM_WORDS];

    word_t            go_addr;
    logic [IDX_W-1:0] go_idx;
    logic             go_store;

    assign go_addr  = addr_q[mem_go_tag];
    assign go_idx   = go_addr[IDX_W+1:2];  // Word index.
    assign go_store = (op_q[mem_go_tag] == SW);

    always_ff @(posedge clk) begin
        if (iss.valid) begin
            addr_q[iss.tag] <= iss.a + iss.imm;
            data_q[iss.tag] <= iss.b;
            op_q[iss.tag]   <= iss.op;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_go && go_store) begin
            mem[go_idx] <= data_q[mem_go_tag];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= iss.valid || mem_go;
        end
    end

    // Buffer never sends mem_go in an issue cycle, so the two never collide.
    always_ff @(posedge clk) begin
        if (mem_go) begin
            res.tag   <= mem_go_tag;
            res.kind  <= VALUE;
            res.value <= go_store ? '0 : mem[go_idx];  // Stores report zero.
        end else begin
            res.tag   <= iss.tag;
            res.kind  <= ADDR_READY;
            res.value <= '0;
        end
    end

endmodule

// ==== hdl/reorder_buffer.sv ====
module reorder_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                dispatch,
    input  isa_pkg::op_t        disp_op,
    input  isa_pkg::reg_idx_t   disp_rd,
    input  isa_pkg::word_t      disp_src1,
    input  isa_pkg::word_t      disp_src2,
    input  isa_pkg::word_t      disp_imm,
    input  isa_pkg::word_t      disp_pc,
    exec_if.issuer              alu_issue,
    exec_if.issuer              lsu_issue,
    cdb_if.consumer             alu_res,
    cdb_if.consumer             lsu_res,
    output logic                mem_go,
    output rob_pkg::rob_tag_t   mem_go_tag,
    output logic                rob_full,
    output logic                commit,
    output isa_pkg::reg_idx_t   commit_rd,
    output isa_pkg::word_t      commit_value,
    output logic                redirect,
    output isa_pkg::word_t      redirect_pc
);
    import isa_pkg::*;
    import rob_pkg::*;

    op_t          ent_op    [ROB_DEPTH];
    reg_idx_t     ent_rd    [ROB_DEPTH];
    word_t        ent_pc    [ROB_DEPTH];
    word_t        ent_imm   [ROB_DEPTH];
    word_t        ent_value [ROB_DEPTH];
    entry_state_t ent_state [ROB_DEPTH];

    rob_tag_t head;
    rob_tag_t tail;
    rob_cnt_t count;
    rob_cnt_t count_next;

    logic accept;
    logic retire;
    logic head_go;
    logic head_redirect;

    function automatic entry_state_t kind_state(result_kind_t kind);
        case (kind)
            TAKEN:      return DONE;
            NOT_TAKEN:  return DONE_NOT_TAKEN;
            ADDR_READY: return MEM_READY;
            default:    return DONE;
        endcase
    endfunction

    assign accept = dispatch && !rob_full;
    assign retire = (count != 0) && (ent_state[head] inside {DONE, DONE_NOT_TAKEN});

    // Hold mem_go while an LSU issue is going out, so results never overlap.
    assign head_go = (count != 0) && (ent_state[head] == MEM_READY)
                     && !(accept && is_mem(disp_op));

    assign head_redirect = (ent_state[head] == DONE)
                           && (is_branch(ent_op[head]) || ent_op[head] == JAL);

    always_comb begin
        count_next = count;
        if (accept && !retire) begin
            count_next = count + 1'b1;
        end else if (retire && !accept) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head            <= '0;
            tail            <= '0;
            count           <= '0;
            rob_full        <= 1'b0;
            commit          <= 1'b0;
            redirect        <= 1'b0;
            mem_go          <= 1'b0;
            mem_go_tag      <= '0;
            alu_issue.valid <= 1'b0;
            lsu_issue.valid <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_state[i] <= EXECUTING;
            end
        end else begin
            count           <= count_next;
            rob_full        <= (count_next == ROB_DEPTH);
            alu_issue.valid <= accept && !is_mem(disp_op) && !done_at_dispatch(disp_op);
            lsu_issue.valid <= accept && is_mem(disp_op);
            if (accept) begin
                tail            <= tail + 1'b1;
                ent_state[tail] <= done_at_dispatch(disp_op) ? DONE : EXECUTING;
            end
            if (alu_res.valid) begin
                ent_state[alu_res.tag] <= kind_state(alu_res.kind);
            end
            if (lsu_res.valid) begin
                ent_state[lsu_res.tag] <= kind_state(lsu_res.kind);
            end
            mem_go     <= head_go;
            mem_go_tag <= head;
            if (head_go) begin
                ent_state[head] <= EXECUTING;  // Wait for the load or store result.
            end
            commit   <= retire;
            redirect <= retire && head_redirect;
            if (retire) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ent_op[tail]  <= disp_op;
            ent_pc[tail]  <= disp_pc;
            ent_imm[tail] <= disp_imm;
            if (is_branch(disp_op) || disp_op == SW || disp_op == NOP) begin
                ent_rd[tail] <= '0;
            end else begin
                ent_rd[tail] <= disp_rd;
            end
            case (disp_op)
                LUI:     ent_value[tail] <= disp_imm;
                JAL:     ent_value[tail] <= disp_pc + 32'd4;  // Link address.
                default: ent_value[tail] <= '0;
            endcase
        end
        if (alu_res.valid && alu_res.kind == VALUE) begin
            ent_value[alu_res.tag] <= alu_res.value;
        end
        if (lsu_res.valid && lsu_res.kind == VALUE) begin
            ent_value[lsu_res.tag] <= lsu_res.value;
        end
    end

    // Same payload to both units, valid picks the one.
    always_ff @(posedge clk) begin
        alu_issue.op  <= disp_op;
        alu_issue.tag <= tail;
        alu_issue.a   <= disp_src1;
        alu_issue.b   <= disp_src2;
        alu_issue.imm <= disp_imm;
        alu_issue.pc  <= disp_pc;
        lsu_issue.op  <= disp_op;
        lsu_issue.tag <= tail;
        lsu_issue.a   <= disp_src1;
        lsu_issue.b   <= disp_src2;
        lsu_issue.imm <= disp_imm;
        lsu_issue.pc  <= disp_pc;
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit_rd    <= ent_rd[head];
            commit_value <= ent_value[head];
            redirect_pc  <= ent_pc[head] + ent_imm[head];
        end
    end

endmodule

// ==== hdl/rob_subsys.sv ====
module rob_subsys (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatch,
    input  isa_pkg::op_t      disp_op,
    input  isa_pkg::reg_idx_t disp_rd,
    input  isa_pkg::word_t    disp_src1,
    input  isa_pkg::word_t    disp_src2,
    input  isa_pkg::word_t    disp_imm,
    input  isa_pkg::word_t    disp_pc,
    output logic              rob_full,
    output logic              commit,
    output isa_pkg::reg_idx_t commit_rd,
    output isa_pkg::word_t    commit_value,
    output logic              redirect,
    output isa_pkg::word_t    redirect_pc
);
    import rob_pkg::*;

    exec_if alu_iss ();
    exec_if lsu_iss ();
    cdb_if  alu_cdb ();
    cdb_if  lsu_cdb ();

    logic     mem_go;
    rob_tag_t mem_go_tag;

    reorder_buffer rob0 (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatch),
        .disp_op      (disp_op),
        .disp_rd      (disp_rd),
        .disp_src1    (disp_src1),
        .disp_src2    (disp_src2),
        .disp_imm     (disp_imm),
        .disp_pc      (disp_pc),
        .alu_issue    (alu_iss.issuer),
        .lsu_issue    (lsu_iss.issuer),
        .alu_res      (alu_cdb.consumer),
        .lsu_res      (lsu_cdb.consumer),
        .mem_go       (mem_go),
        .mem_go_tag   (mem_go_tag),
        .rob_full     (rob_full),
        .commit       (commit),
        .commit_rd    (commit_rd),
        .commit_value (commit_value),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    alu_unit alu0 (
        .clk (clk),
        .rst (rst),
        .iss (alu_iss.unit),
        .res (alu_cdb.producer)
    );

    lsu_unit lsu0 (
        .clk        (clk),
        .rst        (rst),
        .iss        (lsu_iss.unit),
        .res        (lsu_cdb.producer),
        .mem_go     (mem_go),
        .mem_go_tag (mem_go_tag)
    );

endmodule

// ==== sim/rob_model.svh ====
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

typedef struct {
    reg_idx_t rd;
    word_t    value;
    bit       redir;
    word_t    target;
} commit_t;

commit_t exp_q [$];  // Commits still expected, oldest first.
word_t   model_regs [32];
word_t   model_mem [64];

task automatic model_reset();
    exp_q.delete();
    foreach (model_regs[i]) model_regs[i] = '0;
    foreach (model_mem[i]) model_mem[i] = '0;
endtask

// Executes one accepted instruction in program order.
task automatic model_exec(op_t op, reg_idx_t rd, word_t a, word_t b, word_t imm, word_t pc);
    commit_t c;
    word_t   addr;
    addr     = a + imm;
    c.rd     = (op inside {BEQ, BNE, BLT, BGE, SW, NOP}) ? 5'd0 : rd;
    c.value  = '0;
    c.redir  = 1'b0;
    c.target = pc + imm;
    case (op)
        ADD: c.value = a + b;
        SUB: c.value = a - b;
        AND: c.value = a & b;
        OR:  c.value = a | b;
        XOR: c.value = a ^ b;
        SLT: c.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        SLL: c.value = a << b[4:0];
        SRL: c.value = a >> b[4:0];
        BEQ: c.redir = (a == b);
        BNE: c.redir = (a != b);
        BLT: c.redir = ($signed(a) < $signed(b));
        BGE: c.redir = ($signed(a) >= $signed(b));
        LUI: c.value = imm;
        JAL: begin
            c.value = pc + 32'd4;
            c.redir = 1'b1;
        end
        LW:  c.value = model_mem[addr[7:2]];
        SW:  model_mem[addr[7:2]] = b;
        default: ;
    endcase
    if (c.rd != 0) begin
        model_regs[c.rd] = c.value;
    end
    exp_q.push_back(c);
endtask

`endif

// ==== sim/tb_rob_subsys.sv ====
module tb_rob_subsys;
    timeunit 1ns;
    timeprecision 100ps;
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int TOTAL_INSTR = 200 + 60 + 100 + 120 + 150 + 80 + ROB_DEPTH;

    logic     clk = 1'b0;
    logic     rst;
    logic     dispatch;
    op_t      disp_op;
    reg_idx_t disp_rd;
    word_t    disp_src1;
    word_t    disp_src2;
    word_t    disp_imm;
    word_t    disp_pc;
    logic     rob_full;
    logic     commit;
    reg_idx_t commit_rd;
    word_t    commit_value;
    logic     redirect;
    word_t    redirect_pc;

    string cur_test;
    int    errors;
    int    n_pass;
    int    n_fail;
    int    accepted;
    int    committed;
    bit    saw_full;
    word_t pc_next = 32'h1000;

    `include "rob_model.svh"

    rob_subsys dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_reg(string name, reg_idx_t exp, reg_idx_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, bit exp, bit act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    // Registered commit outputs are stable at the falling edge.
    always @(negedge clk) begin : monitor
        commit_t c;
        if (rst && commit) begin
            committed++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR %s: commit to rd %0d with nothing outstanding",
                         cur_test, commit_rd);
            end else begin
                c = exp_q.pop_front();
                check_reg({cur_test, " commit_rd"}, c.rd, commit_rd);
                if (c.rd != 0) begin
                    check_word({cur_test, " commit_value"}, c.value, commit_value);
                end
                check_flag({cur_test, " redirect"}, c.redir, redirect);
                if (c.redir) begin
                    check_word({cur_test, " redirect_pc"}, c.target, redirect_pc);
                end
            end
        end
        if (rst) begin
            saw_full = saw_full | rob_full;
            check_flag({cur_test, " rob_full"}, (accepted - committed) == ROB_DEPTH, rob_full);
            if (!commit) begin
                check_flag({cur_test, " redirect without commit"}, 1'b0, redirect);
            end
        end
    end

    task automatic apply_reset();
        rst      <= 1'b0;
        dispatch <= 1'b0;
        repeat (10) @(posedge clk);
        accepted  = 0;
        committed = 0;
        rst      <= 1'b1;
    endtask

    // Drives one instruction and holds it until the buffer takes it.
    task automatic send_instr(op_t op, reg_idx_t rd, word_t a, word_t b, word_t imm);
        dispatch  <= 1'b1;
        disp_op   <= op;
        disp_rd   <= rd;
        disp_src1 <= a;
        disp_src2 <= b;
        disp_imm  <= imm;
        disp_pc   <= pc_next;
        @(posedge clk);
        while (rob_full) begin
            @(posedge clk);  // Held until the buffer has room.
        end
        accepted++;
        model_exec(op, rd, a, b, imm, pc_next);
        pc_next += 4;
    endtask

    // Mode 0 ALU, 1 branch, 2 memory, 3 everything.
    function automatic op_t pick_op(int mode);
        op_t alu_ops [8] = '{ADD, SUB, AND, OR, XOR, SLT, SLL, SRL};
        op_t br_ops  [5] = '{BEQ, BNE, BLT, BGE, JAL};
        int  r;
        r = $urandom % 10;
        if ((mode == 1 && r < 5) || (mode == 3 && r inside {6, 7})) begin
            return br_ops[$urandom % 5];
        end
        if ((mode == 2 && r < 6) || (mode == 3 && r inside {4, 5})) begin
            return ($urandom % 2 == 0) ? LW : SW;
        end
        if (mode == 3 && r == 8) begin
            return LUI;
        end
        if (mode == 3 && r == 9) begin
            return NOP;
        end
        return alu_ops[$urandom % 8];
    endfunction

    task automatic run_test(string name, int n, int mode, bit gaps, int span, bit do_reset);
        int       err_start;
        op_t      op;
        reg_idx_t rd;
        word_t    a;
        word_t    b;
        word_t    imm;
        cur_test  = name;
        err_start = errors;
        saw_full  = 1'b0;
        if (do_reset) begin
            // Stores fill the buffer so reset meets a full one.
            for (int i = 0; i < ROB_DEPTH; i++) begin
                send_instr(SW, 5'd0, word_t'(i * 4), $urandom, '0);
            end
            apply_reset();
            model_reset();
            check_flag({name, " commit after reset"}, 1'b0, commit);
            check_flag({name, " redirect after reset"}, 1'b0, redirect);
            check_flag({name, " rob_full after reset"}, 1'b0, rob_full);
        end
        for (int i = 0; i < n; i++) begin
            op  = pick_op(mode);
            rd  = reg_idx_t'($urandom % 32);
            a   = $urandom;
            b   = $urandom;
            imm = $urandom;
            if ($urandom % 2 == 0) begin
                a = model_regs[$urandom % 32];  // Source value from an earlier result.
            end
            if (op == LW || op == SW) begin
                a   = ($urandom % span) * 4;  // Word-aligned address below 256.
                imm = ($urandom % span) * 4;
            end else if (op inside {BEQ, BNE, BLT, BGE, JAL}) begin
                imm = ($urandom % 64) * 4;
                if ($urandom % 2 == 0) begin
                    b = a;
                end
            end
            if (gaps && $urandom % 4 == 0) begin
                dispatch <= 1'b0;
                @(posedge clk);
            end
            send_instr(op, rd, a, b, imm);
        end
        dispatch <= 1'b0;
        repeat (400) begin
            if (exp_q.size() == 0) break;
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("ERROR %s: %0d expected commits never arrived", name, exp_q.size());
            exp_q.delete();
        end
        if (mode == 2 && !gaps) begin
            check_flag({name, " rob_full seen"}, 1'b1, saw_full);
        end
        if (errors == err_start) begin
            n_pass++;
            $display("%s: passed, %0d instructions", name, n);
        end else begin
            n_fail++;
            $display("%s: failed with %0d errors", name, errors - err_start);
        end
    endtask

    initial begin
        void'($urandom(50));
        rst       = 1'b0;
        dispatch  = 1'b0;
        disp_op   = NOP;
        disp_rd   = '0;
        disp_src1 = '0;
        disp_src2 = '0;
        disp_imm  = '0;
        disp_pc   = '0;
        apply_reset();
        model_reset();
        run_test("alu_stream", 200, 0, 1'b1, 32, 1'b0);
        run_test("full_buffer", 60, 2, 1'b0, 32, 1'b0);
        run_test("branch_jal", 100, 1, 1'b1, 32, 1'b0);
        run_test("mem_order", 120, 2, 1'b1, 2, 1'b0);  // Only a few addresses.
        run_test("mixed", 150, 3, 1'b1, 32, 1'b0);
        run_test("reset", 80, 3, 1'b1, 32, 1'b1);
        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(TOTAL_INSTR * 40 * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Something failed");
        $finish;
    end

endmodule

// ==== rob_subsys.f ====
+incdir+sim
hdl/isa_pkg.sv
hdl/rob_pkg.sv
hdl/rob_ifs.sv
hdl/alu_unit.sv
hdl/lsu_unit.sv
hdl/reorder_buffer.sv
hdl/rob_subsys.sv
sim/tb_rob_subsys.sv
